// File: tests/decode_golden.txt
# name mode(n s f p q) instr tag, src1 renamed value tag rob_ready rob_value, src2 the same
# expect unit(r l x) op rd fill_rd imm, src1 value waiting tag, src2 value waiting tag
addi n ffd08293 3 0 11 0 0 0 0 99 0 0 0 r 18 5 1 fffffffd 11 0 0 0 0 0
add n 002081b3 1 1 55 2 1 44 1 66 7 0 77 r 27 3 1 00000000 44 0 0 0 1 7
sub n 40730233 2 0 a 0 0 0 0 b 0 0 0 r 28 4 1 00000000 a 0 0 b 0 0
add_x0 n 00200433 1a 1 dd 5 0 ee 0 12 0 0 0 r 27 8 1 00000000 0 0 0 12 0 0
slli n 00451493 4 0 5 0 0 0 0 0 0 0 0 r 24 9 1 00000004 5 0 0 0 0 0
srai n 40365593 5 1 0 3 0 0 0 0 0 0 0 r 26 11 1 00000403 0 1 3 0 0 0
lui n 123456b7 6 0 7 0 0 0 0 8 0 0 0 r 0 13 1 12345000 0 0 0 0 0 0
auipc n fffff717 7 0 7 0 0 0 0 8 0 0 0 r 1 14 1 fffff000 0 0 0 0 0 0
jal n ff9ff0ef 8 1 1 2 1 3 0 4 0 0 0 r 2 1 1 fffffff8 0 0 0 0 0 0
jalr n 01028167 9 0 abc 0 0 0 0 0 0 0 0 r 3 2 1 00000010 abc 0 0 0 0 0
beq n fe2088e3 a 0 1 0 0 0 1 0 6 1 2 r 4 17 0 fffffff0 1 0 0 2 0 0
bltu n 0041e463 b 1 0 9 0 0 1 0 a 0 0 r 8 8 0 00000008 0 1 9 0 1 a
lw n 00c12783 c 0 2000 0 0 0 0 0 0 0 0 l 12 15 1 0000000c 2000 0 0 0 0 0
lbu n fff3c303 d 1 0 4 1 3000 0 0 0 0 0 l 13 6 1 ffffffff 3000 0 0 0 0 0
sw n fe542e23 e 0 4000 0 0 0 1 0 3c 0 0 l 17 28 0 fffffffc 4000 0 0 0 1 c
sb_x0 n 000082a3 f 0 100 0 0 0 1 0 3 0 0 l 15 5 0 00000005 100 0 0 0 0 0
stall s 00100093 1 0 0 0 0 0 0 0 0 0 0 x 0 0 0 00000000 0 0 0 0 0 0
flush f 00100093 1 0 0 0 0 0 0 0 0 0 0 x 0 0 0 00000000 0 0 0 0 0 0
bad_opc n 0000007f 1 0 0 0 0 0 0 0 0 0 0 x 0 0 0 00000000 0 0 0 0 0 0
bad_f7 n 02208133 1 0 0 0 0 0 0 0 0 0 0 x 0 0 0 00000000 0 0 0 0 0 0
xori p 0ffaca13 4 0 f0 0 0 0 0 0 0 0 0 r 21 20 1 000000ff f0 0 0 0 0 0
lh q 002a1b03 5 1 0 6 0 0 0 0 0 0 0 l 11 22 1 00000002 0 1 6 0 0 0
and n 003170b3 3 0 f0f0 0 0 0 1 0 2 1 f0f r 36 1 1 00000000 f0f0 0 0 f0f 0 0

// File: project.f
hdl/decode_pkg.sv
hdl/op_decoder.sv
hdl/imm_gen.sv
hdl/decode_stage.sv
hdl/operand_resolver.sv
hdl/dispatch_router.sv
hdl/decoder_top.sv
tests/tb_decoder.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 -f project.f --top-module tb_decoder \
    -Mdir obj_dir -o tb_decoder &&
./obj_dir/tb_decoder > sim.log 2>&1 ||
{ cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// File: tests/tb_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module tb_decoder;
    import decode_pkg::*;

    localparam int tag_w = 4;
    localparam int timeout_cycles = 10;
    localparam int max_tests = 32;

    // one line of the golden file
    typedef struct packed {
        logic [8*12-1:0] name;
        logic [7:0]      mode;
        instr_t          instr;
        tag_t            tag;
        src_answer_t     ans1;
        src_answer_t     ans2;
        logic [7:0]      unit;
        logic [5:0]      op;
        reg_idx_t        rd;
        logic            fill_rd;
        data_t           imm;
        operand_t        src1;
        operand_t        src2;
    } golden_t;

    logic        clk;
    logic        reset;
    logic        fetch_valid;
    instr_t      fetch_instr;
    data_t       fetch_pc;
    tag_t        rob_free_tag;
    logic        stall;
    logic        flush;
    src_answer_t src1_answer;
    src_answer_t src2_answer;
    reg_query_t  reg_query;
    dispatch_t   dispatch;
    logic        rs_valid;
    logic        lsb_valid;

    golden_t         golden [0:max_tests-1];
    int              entries;
    int              test_errors;
    int              pass_count;
    int              fail_count;
    logic [8*12-1:0] cur_name;

    decoder_top #(.tag_w(tag_w)) dut0 (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_instr  (fetch_instr),
        .fetch_pc     (fetch_pc),
        .rob_free_tag (rob_free_tag),
        .stall        (stall),
        .flush        (flush),
        .src1_answer  (src1_answer),
        .src2_answer  (src2_answer),
        .reg_query    (reg_query),
        .dispatch     (dispatch),
        .rs_valid     (rs_valid),
        .lsb_valid    (lsb_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic load_golden();
        int              fd;
        int              got;
        string           line;
        logic [31:0]     f [0:21];
        logic [8*12-1:0] name;
        logic [7:0]      mode;
        logic [7:0]      unit;
        golden_t         g;
        entries = 0;
        fd = $fopen("tests/decode_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/decode_golden.txt");
        end else begin
            while (!$feof(fd) && entries < max_tests) begin
                line = "";
                got = $fgets(line, fd);
                // skip comments and blank lines
                if (got > 1 && line[0] != "#") begin
                    got = $sscanf(line,
                        "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %s %d %d %d %h %h %h %h %h %h %h",
                        name, mode, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], unit, f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                        f[19], f[20], f[21]);
                    if (got == 25) begin
                        g.name = name;
                        g.mode = mode;
                        g.instr = f[0];
                        g.tag = f[1][7:0];
                        g.ans1 = {f[2][0], f[3], f[4][7:0], f[5][0], f[6]};
                        g.ans2 = {f[7][0], f[8], f[9][7:0], f[10][0], f[11]};
                        g.unit = unit;
                        g.op = f[12][5:0];
                        g.rd = f[13][4:0];
                        g.fill_rd = f[14][0];
                        g.imm = f[15];
                        g.src1 = {f[16], f[17][0], f[18][7:0]};
                        g.src2 = {f[19], f[20][0], f[21][7:0]};
                        golden[entries] = g;
                        entries++;
                    end else begin
                        $display("golden line could not be parsed: %0s", line);
                        fail_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic data_t pc_of(input int idx);
        return 32'h0000_1000 + 32'(idx) * 32'd4;
    endfunction

    // register lookup implied by the rv32i encoding
    function automatic reg_query_t expected_query(input instr_t instr);
        reg_query_t q;
        q.rs1 = instr[19:15];
        q.rs2 = instr[24:20];
        case (instr[6:0])
            // lui, auipc and jal read no register
            7'b0110111, 7'b0010111, 7'b1101111: begin
                q.need_rs1 = 1'b0;
                q.need_rs2 = 1'b0;
            end
            // stores, branches and register-register ops
            7'b0100011, 7'b1100011, 7'b0110011: begin
                q.need_rs1 = 1'b1;
                q.need_rs2 = 1'b1;
            end
            // loads, immediate alu ops and jalr read rs1 only
            default: begin
                q.need_rs1 = 1'b1;
                q.need_rs2 = 1'b0;
            end
        endcase
        return q;
    endfunction

    task automatic drive_fetch(input int idx);
        fetch_valid  = 1'b1;
        fetch_instr  = golden[idx].instr;
        fetch_pc     = pc_of(idx);
        rob_free_tag = golden[idx].tag;
        stall        = (golden[idx].mode == "s");
        flush        = (golden[idx].mode == "f");
    endtask

    task automatic drive_answers(input int idx);
        src1_answer = golden[idx].ans1;
        src2_answer = golden[idx].ans2;
    endtask

    task automatic idle_fetch();
        fetch_valid = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
    endtask

    task automatic wait_dispatch(output logic got);
        int n;
        got = 1'b0;
        n = 0;
        while (!got && n < timeout_cycles) begin
            @(negedge clk);
            got = rs_valid || lsb_valid;
            n++;
        end
    endtask

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %0s %0s: expected %h, actual %h", cur_name, field, expected,
                     actual);
            test_errors++;
        end
    endtask

    task automatic check_dispatch(input int idx);
        golden_t    g;
        tag_t       exp_tag;
        reg_query_t exp_query;
        g = golden[idx];
        // only the low tag_w bits of the free tag come through
        exp_tag = g.tag & tag_t'((1 << tag_w) - 1);
        exp_query = expected_query(g.instr);
        check_value("query rs1", 32'(exp_query.rs1), 32'(reg_query.rs1));
        check_value("query rs2", 32'(exp_query.rs2), 32'(reg_query.rs2));
        check_value("query need_rs1", 32'(exp_query.need_rs1), 32'(reg_query.need_rs1));
        check_value("query need_rs2", 32'(exp_query.need_rs2), 32'(reg_query.need_rs2));
        check_value("op", 32'(g.op), 32'(dispatch.op));
        check_value("rd", 32'(g.rd), 32'(dispatch.rd));
        check_value("rd_tag", 32'(exp_tag), 32'(dispatch.rd_tag));
        check_value("fill_rd", 32'(g.fill_rd), 32'(dispatch.fill_rd));
        check_value("imm", g.imm, dispatch.imm);
        check_value("pc", pc_of(idx), dispatch.pc);
        check_value("src1 value", g.src1.value, dispatch.src1.value);
        check_value("src1 waiting", 32'(g.src1.waiting), 32'(dispatch.src1.waiting));
        check_value("src1 tag", 32'(g.src1.tag), 32'(dispatch.src1.tag));
        check_value("src2 value", g.src2.value, dispatch.src2.value);
        check_value("src2 waiting", 32'(g.src2.waiting), 32'(dispatch.src2.waiting));
        check_value("src2 tag", 32'(g.src2.tag), 32'(dispatch.src2.tag));
    endtask

    task automatic judge(input int idx, input logic got);
        golden_t g;
        g = golden[idx];
        cur_name = g.name;
        if (g.unit == "x") begin
            if (got) begin
                $display("%0s: dispatch seen where none was expected", g.name);
                test_errors++;
            end
        end else if (!got) begin
            $display("%0s: no dispatch within %0d cycles", g.name, timeout_cycles);
            test_errors++;
        end else begin
            if (rs_valid !== (g.unit == "r") || lsb_valid !== (g.unit == "l")) begin
                $display("%0s: wrong unit valid, rs_valid %b lsb_valid %b", g.name, rs_valid,
                         lsb_valid);
                test_errors++;
            end
            check_dispatch(idx);
        end
    endtask

    task automatic close_test(input logic [8*12-1:0] name);
        if (test_errors == 0) begin
            pass_count++;
            $display("%0s: ok", name);
        end else begin
            fail_count++;
            $display("%0s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic run_single(input int idx);
        logic got;
        @(posedge clk);
        #2;
        drive_fetch(idx);
        drive_answers(idx);
        @(posedge clk);
        #2;
        idle_fetch();
        wait_dispatch(got);
        judge(idx, got);
        if (got) begin
            // a dispatch is a single pulse
            @(negedge clk);
            if (rs_valid || lsb_valid) begin
                $display("%0s: valid stayed high for a second cycle", golden[idx].name);
                test_errors++;
            end
        end
        close_test(golden[idx].name);
    endtask

    task automatic run_pair(input int idx);
        logic got;
        @(posedge clk);
        #2;
        drive_fetch(idx);
        drive_answers(idx);
        @(posedge clk);
        #2;
        // second strobe right behind the first
        drive_fetch(idx + 1);
        wait_dispatch(got);
        judge(idx, got);
        close_test(golden[idx].name);
        @(posedge clk);
        #2;
        idle_fetch();
        drive_answers(idx + 1);
        @(negedge clk);
        judge(idx + 1, rs_valid || lsb_valid);
        close_test(golden[idx + 1].name);
    endtask

    initial begin
        int idx;
        int gap;
        int k;
        reset        = 1'b1;
        fetch_valid  = 1'b0;
        fetch_instr  = '0;
        fetch_pc     = '0;
        rob_free_tag = '0;
        stall        = 1'b0;
        flush        = 1'b0;
        src1_answer  = '0;
        src2_answer  = '0;
        test_errors  = 0;
        pass_count   = 0;
        fail_count   = 0;
        cur_name     = "reset";
        void'($urandom(58555));
        load_golden();
        if (entries == 0) begin
            $display("golden file missing or empty");
            fail_count++;
        end else begin
            // valids stay low through reset and a few idle cycles
            for (k = 0; k < 11; k++) begin
                @(posedge clk);
                #2;
                if (k == 7) begin
                    reset = 1'b0;
                end
                @(negedge clk);
                if (rs_valid !== 1'b0 || lsb_valid !== 1'b0) begin
                    $display("reset: a valid is high before any strobe");
                    test_errors++;
                end
            end
            close_test("reset");
            idx = 0;
            while (idx < entries) begin
                if (golden[idx].mode == "p" && idx + 1 < entries) begin
                    run_pair(idx);
                    idx += 2;
                end else begin
                    run_single(idx);
                    idx++;
                end
                gap = int'($urandom % 4);
                repeat (gap) @(posedge clk);
            end
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/decoder_top.sv
`timescale 1ns/100ps
`default_nettype none

module decoder_top #(
    parameter int tag_w = 4
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          fetch_valid,
    input  wire decode_pkg::instr_t      fetch_instr,
    input  wire decode_pkg::data_t       fetch_pc,
    input  wire decode_pkg::tag_t        rob_free_tag,
    input  wire                          stall,
    input  wire                          flush,
    input  wire decode_pkg::src_answer_t src1_answer,
    input  wire decode_pkg::src_answer_t src2_answer,
    output wire decode_pkg::reg_query_t  reg_query,
    output wire decode_pkg::dispatch_t   dispatch,
    output wire                          rs_valid,
    output wire                          lsb_valid
);
    import decode_pkg::*;

    decoded_t dec;
    tag_t     dec_tag;
    logic     dec_valid;

    decode_stage #(.tag_w(tag_w)) stage0 (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .stall        (stall),
        .flush        (flush),
        .fetch_instr  (fetch_instr),
        .fetch_pc     (fetch_pc),
        .rob_free_tag (rob_free_tag),
        .dec          (dec),
        .dec_tag      (dec_tag),
        .dec_valid    (dec_valid)
    );

    dispatch_router #(.tag_w(tag_w)) router0 (
        .dec         (dec),
        .dec_tag     (dec_tag),
        .dec_valid   (dec_valid),
        .src1_answer (src1_answer),
        .src2_answer (src2_answer),
        .reg_query   (reg_query),
        .dispatch    (dispatch),
        .rs_valid    (rs_valid),
        .lsb_valid   (lsb_valid)
    );

endmodule

`default_nettype wire

// File: hdl/dispatch_router.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_router #(
    parameter int tag_w = 4
) (
    input  wire decode_pkg::decoded_t    dec,
    input  wire decode_pkg::tag_t        dec_tag,
    input  wire                          dec_valid,
    input  wire decode_pkg::src_answer_t src1_answer,
    input  wire decode_pkg::src_answer_t src2_answer,
    output decode_pkg::reg_query_t       reg_query,
    output decode_pkg::dispatch_t        dispatch,
    output logic                         rs_valid,
    output logic                         lsb_valid
);
    import decode_pkg::*;

    operand_t src1;
    operand_t src2;

    operand_resolver #(.tag_w(tag_w)) res_src1 (
        .index   (dec.rs1),
        .needed  (dec.need_rs1),
        .answer  (src1_answer),
        .operand (src1)
    );

    operand_resolver #(.tag_w(tag_w)) res_src2 (
        .index   (dec.rs2),
        .needed  (dec.need_rs2),
        .answer  (src2_answer),
        .operand (src2)
    );

    // straight from the stage register
    assign reg_query.rs1      = dec.rs1;
    assign reg_query.rs2      = dec.rs2;
    assign reg_query.need_rs1 = dec.need_rs1;
    assign reg_query.need_rs2 = dec.need_rs2;

    assign dispatch.op      = dec.op;
    assign dispatch.rd      = dec.rd;
    assign dispatch.rd_tag  = dec_tag;
    assign dispatch.fill_rd = dec.fill_rd;
    assign dispatch.imm     = dec.imm;
    assign dispatch.pc      = dec.pc;
    assign dispatch.src1    = src1;
    assign dispatch.src2    = src2;

    always_comb begin
        rs_valid  = dec_valid && (dec.unit == unit_rs);
        lsb_valid = dec_valid && (dec.unit == unit_lsb);
        a_one_unit: assert (!(rs_valid && lsb_valid));
    end

endmodule

`default_nettype wire

// File: hdl/operand_resolver.sv
`timescale 1ns/100ps
`default_nettype none

module operand_resolver #(
    parameter int tag_w = 4
) (
    input  wire decode_pkg::reg_idx_t    index,
    input  wire                          needed,
    input  wire decode_pkg::src_answer_t answer,
    output decode_pkg::operand_t         operand
);

    always_comb begin
        operand = '0;
        // x0 and unused sources stay zero and ready
        if (needed && index != '0) begin
            if (!answer.reg_renamed) begin
                operand.value = answer.reg_value;
            end else if (answer.rob_ready) begin
                // producer finished but not yet committed
                operand.value = answer.rob_value;
            end else begin
                operand.waiting = 1'b1;
                operand.tag[tag_w-1:0] = answer.reg_tag[tag_w-1:0];
            end
        end
        if (operand.waiting) begin
            a_wait_nonzero: assert (index != '0);
        end
    end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage #(
    parameter int tag_w = 4
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     fetch_valid,
    input  wire                     stall,
    input  wire                     flush,
    input  wire decode_pkg::instr_t fetch_instr,
    input  wire decode_pkg::data_t  fetch_pc,
    input  wire decode_pkg::tag_t   rob_free_tag,
    output decode_pkg::decoded_t    dec,
    output decode_pkg::tag_t        dec_tag,
    output logic                    dec_valid
);
    import decode_pkg::*;

    op_e   op;
    unit_e unit;
    logic  need_rs1;
    logic  need_rs2;
    logic  fill_rd;
    logic  legal;
    data_t imm;
    tag_t  free_tag;
    logic  accept;

    op_decoder dec0 (
        .instr    (fetch_instr),
        .op       (op),
        .unit     (unit),
        .need_rs1 (need_rs1),
        .need_rs2 (need_rs2),
        .fill_rd  (fill_rd),
        .legal    (legal)
    );

    imm_gen imm0 (
        .instr (fetch_instr),
        .imm   (imm)
    );

    // only the low tag_w bits name a rob entry
    always_comb begin
        free_tag = '0;
        free_tag[tag_w-1:0] = rob_free_tag[tag_w-1:0];
    end

    assign accept = fetch_valid && !stall && !flush && legal;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;
        end
    end

    // decoded fields hold until the next accepted instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            dec.op       <= op;
            dec.unit     <= unit;
            dec.rd       <= fetch_instr[11:7];
            dec.rs1      <= fetch_instr[19:15];
            dec.rs2      <= fetch_instr[24:20];
            dec.need_rs1 <= need_rs1;
            dec.need_rs2 <= need_rs2;
            dec.fill_rd  <= fill_rd;
            dec.imm      <= imm;
            dec.pc       <= fetch_pc;
            dec_tag      <= free_tag;
        end
    end

    a_no_valid_after_flush: assert property (
        @(posedge clk) disable iff (reset) flush |=> !dec_valid
    );

    a_no_valid_after_stall: assert property (
        @(posedge clk) disable iff (reset) stall |=> !dec_valid
    );

endmodule

`default_nettype wire

// File: hdl/imm_gen.sv
`timescale 1ns/100ps
`default_nettype none

module imm_gen (
    input  wire decode_pkg::instr_t instr,
    output decode_pkg::data_t       imm
);
    import decode_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (instr[6:0])
            // i format
            opc_load, opc_op_imm, opc_jalr:
                imm = {{20{sign}}, instr[31:20]};
            opc_store:
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            opc_branch:
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            opc_lui, opc_auipc:
                imm = {instr[31:12], 12'b0};
            opc_jal:
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            // register-register and anything unknown
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/op_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module op_decoder (
    input  wire decode_pkg::instr_t instr,
    output decode_pkg::op_e         op,
    output decode_pkg::unit_e       unit,
    output logic                    need_rs1,
    output logic                    need_rs2,
    output logic                    fill_rd,
    output logic                    legal
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] func3;
    logic [6:0] func7;

    assign opcode = instr[6:0];
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];

    always_comb begin
        op       = op_lui;
        unit     = unit_rs;
        need_rs1 = 1'b0;
        need_rs2 = 1'b0;
        fill_rd  = 1'b1;
        legal    = 1'b1;
        case (opcode)
            opc_lui:   op = op_lui;
            opc_auipc: op = op_auipc;
            opc_jal:   op = op_jal;
            opc_jalr: begin
                op       = op_jalr;
                need_rs1 = 1'b1;
                legal    = (func3 == 3'b000);
            end
            opc_branch: begin
                need_rs1 = 1'b1;
                need_rs2 = 1'b1;
                fill_rd  = 1'b0;
                case (func3)
                    3'b000:  op = op_beq;
                    3'b001:  op = op_bne;
                    3'b100:  op = op_blt;
                    3'b101:  op = op_bge;
                    3'b110:  op = op_bltu;
                    3'b111:  op = op_bgeu;
                    default: legal = 1'b0;
                endcase
            end
            opc_load: begin
                unit     = unit_lsb;
                need_rs1 = 1'b1;
                case (func3)
                    3'b000:  op = op_lb;
                    3'b001:  op = op_lh;
                    3'b010:  op = op_lw;
                    3'b100:  op = op_lbu;
                    3'b101:  op = op_lhu;
                    default: legal = 1'b0;
                endcase
            end
            opc_store: begin
                unit     = unit_lsb;
                need_rs1 = 1'b1;
                need_rs2 = 1'b1;
                fill_rd  = 1'b0;
                case (func3)
                    3'b000:  op = op_sb;
                    3'b001:  op = op_sh;
                    3'b010:  op = op_sw;
                    default: legal = 1'b0;
                endcase
            end
            opc_op_imm: begin
                need_rs1 = 1'b1;
                case (func3)
                    3'b000: op = op_addi;
                    3'b010: op = op_slti;
                    3'b011: op = op_sltiu;
                    3'b100: op = op_xori;
                    3'b110: op = op_ori;
                    3'b111: op = op_andi;
                    3'b001: begin
                        op    = op_slli;
                        legal = (func7 == 7'b0000000);
                    end
                    default: begin
                        // func7 splits logical and arithmetic shift
                        op    = func7[5] ? op_srai : op_srli;
                        legal = (func7 == 7'b0000000) || (func7 == 7'b0100000);
                    end
                endcase
            end
            opc_op: begin
                need_rs1 = 1'b1;
                need_rs2 = 1'b1;
                case (func3)
                    3'b010: op = op_slt;
                    3'b011: op = op_sltu;
                    3'b100: op = op_xor;
                    3'b110: op = op_or;
                    3'b111: op = op_and;
                    3'b001: begin
                        op    = op_sll;
                        legal = (func7 == 7'b0000000);
                    end
                    3'b000: begin
                        op    = func7[5] ? op_sub : op_add;
                        legal = (func7 == 7'b0000000) || (func7 == 7'b0100000);
                    end
                    default: begin
                        op    = func7[5] ? op_sra : op_srl;
                        legal = (func7 == 7'b0000000) || (func7 == 7'b0100000);
                    end
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int xlen = 32;
    localparam int max_tag_w = 8;

    typedef logic [xlen-1:0] instr_t;
    typedef logic [xlen-1:0] data_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [max_tag_w-1:0] tag_t;

    // rv32i major opcodes
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // numbered 0..36 in this order
    typedef enum logic [5:0] {
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_lbu, op_lhu,
        op_sb, op_sh, op_sw,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and
    } op_e;

    typedef enum logic {
        unit_rs  = 1'b0,
        unit_lsb = 1'b1
    } unit_e;

    typedef struct packed {
        op_e      op;
        unit_e    unit;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     need_rs1;
        logic     need_rs2;
        logic     fill_rd;
        data_t    imm;
        data_t    pc;
    } decoded_t;

    // lookup request to the register file
    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     need_rs1;
        logic     need_rs2;
    } reg_query_t;

    typedef struct packed {
        logic  reg_renamed;
        data_t reg_value;
        tag_t  reg_tag;
        logic  rob_ready;
        data_t rob_value;
    } src_answer_t;

    typedef struct packed {
        data_t value;
        logic  waiting;
        tag_t  tag;
    } operand_t;

    typedef struct packed {
        op_e      op;
        reg_idx_t rd;
        tag_t     rd_tag;
        logic     fill_rd;
        data_t    imm;
        data_t    pc;
        operand_t src1;
        operand_t src2;
    } dispatch_t;

endpackage

`default_nettype wire
